// File: Makefile
# Verilator build and run of the MCR3 input block testbench

SIM := obj_dir/Vtb_mcr3_input
SOURCES := $(wildcard src/*.sv tb/*.sv)

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log; cat sim.log
	grep -q "^Simulation PASSED$$" sim.log

$(SIM): mcr3_input.f $(SOURCES)
	verilator --binary --assert -Wno-fatal --top-module tb_mcr3_input \
		-f mcr3_input.f -o Vtb_mcr3_input

clean:
	rm -rf obj_dir sim.log

// File: mcr3_input.f
src/mcr3_input_pkg.sv
src/player_ctl_if.sv
src/player_controls.sv
src/game_config.sv
src/reset_sequencer.sv
src/hold_timer.sv
src/gear_shift.sv
src/input_port_map.sv
src/mcr3_input_top.sv
tb/tb_mcr3_input.sv

// File: src/game_config.sv
//==============================
// Game select and DIP byte capture
// from the download stream
//==============================
`timescale 1ns/100ps

module game_config import mcr3_input_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        ioctl_wr,
	input  logic [7:0]  ioctl_index,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0]  ioctl_dout,
	output game_id_t    game,
	output logic [7:0]  dip0,
	output logic [7:0]  dip1
);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			game <= GAME_RAMPAGE;
			dip0 <= 8'hff;
			dip1 <= 8'hff;
		end else if (ioctl_wr) begin
			if (ioctl_index == DL_INDEX_GAME) begin
				game <= game_id_t'(ioctl_dout);
			end
			// DIP bytes past the second are dropped
			if (ioctl_index == DL_INDEX_DIP && ioctl_addr < 25'(DIP_BYTES)) begin
				if (ioctl_addr[0])
					dip1 <= ioctl_dout;
				else
					dip0 <= ioctl_dout;
			end
		end
	end

endmodule

// File: src/gear_shift.sv
//==============================
// Max RPM gearboxes for two players
// and Power Drive gear toggles
//==============================
`timescale 1ns/100ps

module gear_shift import mcr3_input_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	player_ctl_if.sink p1,
	player_ctl_if.sink p2,
	player_ctl_if.sink p3,
	output logic [3:0] maxrpm_code1,
	output logic [3:0] maxrpm_code2,
	output logic [2:0] pd_gear
);

	gear_t      gear1;
	gear_t      gear2;
	logic [1:0] fire_a_q;
	logic [1:0] fire_b_q;
	logic [2:0] fire_d_q;
	logic [1:0] rise_a;
	logic [1:0] rise_b;
	logic [2:0] rise_d;

	// Start returns to neutral, shifts saturate at both ends
	function automatic gear_t next_gear(gear_t gear, logic start, logic up, logic down);
		if (start)
			return '0;
		else if (up && gear != GEAR_TOP)
			return gear + 3'd1;
		else if (down && gear != 3'd0)
			return gear - 3'd1;
		return gear;
	endfunction

	assign rise_a = {p2.fire_a, p1.fire_a} & ~fire_a_q;
	assign rise_b = {p2.fire_b, p1.fire_b} & ~fire_b_q;
	assign rise_d = {p3.fire_d, p2.fire_d, p1.fire_d} & ~fire_d_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			gear1 <= '0;
			gear2 <= '0;
			pd_gear <= '0;
			fire_a_q <= '0;
			fire_b_q <= '0;
			fire_d_q <= '0;
		end else begin
			fire_a_q <= {p2.fire_a, p1.fire_a};
			fire_b_q <= {p2.fire_b, p1.fire_b};
			fire_d_q <= {p3.fire_d, p2.fire_d, p1.fire_d};
			gear1 <= next_gear(gear1, p1.start, rise_a[0], rise_b[0]);
			gear2 <= next_gear(gear2, p2.start, rise_a[1], rise_b[1]);
			pd_gear <= pd_gear ^ rise_d;
		end
	end

	assign maxrpm_code1 = MAXRPM_GEAR_CODE[gear1];
	assign maxrpm_code2 = MAXRPM_GEAR_CODE[gear2];

endmodule

// File: src/hold_timer.sv
//==============================
// Post-load hold down-counter
//==============================
`timescale 1ns/100ps

module hold_timer import mcr3_input_pkg::*; (
	input  logic clk_sys,
	input  logic reset,
	input  logic hold_start,
	output logic hold_done
);

	logic [15:0] count;

	// Zero means idle
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			count <= '0;
		end else if (hold_start) begin
			count <= HOLD_CYCLES - 16'd1;
		end else if (count != 16'd0) begin
			count <= count - 16'd1;
		end
	end

	// Last cycle of the count, seen by the sequencer at the next edge
	assign hold_done = (count == 16'd1);

endmodule

// File: src/input_port_map.sv
//==============================
// Per-game forming of the five
// active-low CPU input ports
//==============================
`timescale 1ns/100ps

module input_port_map import mcr3_input_pkg::*; (
	input  game_id_t    game,
	input  logic [7:0]  dip0,
	input  logic [7:0]  dip1,
	input  logic        snd_stat,
	player_ctl_if.sink  p1,
	player_ctl_if.sink  p2,
	player_ctl_if.sink  p3,
	input  logic [3:0]  maxrpm_code1,
	input  logic [3:0]  maxrpm_code2,
	input  logic [2:0]  pd_gear,
	output logic [7:0]  input0,
	output logic [7:0]  input1,
	output logic [7:0]  input2,
	output logic [7:0]  input3,
	output logic [7:0]  input4
);

	assign input3 = dip0;

	// Unsupported games read idle on every port
	always_comb begin
		input0 = 8'hff;
		input1 = 8'hff;
		input2 = 8'hff;
		input4 = 8'hff;
		case (game)
			GAME_RAMPAGE: begin
				input0 = ~{2'b00, dip1[0], 3'b000, p2.coin, p1.coin};
				input1 = ~{2'b00, p1.fire_b, p1.fire_a, p1.left, p1.down, p1.right, p1.up};
				input2 = ~{2'b00, p2.fire_b, p2.fire_a, p2.left, p2.down, p2.right, p2.up};
				input4 = ~{snd_stat, 1'b0, p3.fire_b, p3.fire_a,
					p3.left, p3.down, p3.right, p3.up};
			end
			GAME_POWERDRIVE: begin
				input0 = ~{2'b00, dip1[0], 2'b00, p3.coin, p2.coin, p1.coin};
				// Players 1 and 2 share a port, gear bit between buttons
				input1 = ~{p2.fire_b, p2.fire_a, pd_gear[1], p2.fire_c,
					p1.fire_b, p1.fire_a, pd_gear[0], p1.fire_c};
				input2 = ~{snd_stat, 3'b000, p3.fire_b, p3.fire_a, pd_gear[2], p3.fire_c};
			end
			GAME_MAXRPM: begin
				input0 = ~{dip1[0], 3'b000, p1.start, p2.start, p1.coin, p2.coin};
				// Gear codes are already in port polarity
				input2 = {maxrpm_code1, maxrpm_code2};
			end
			default: ;
		endcase
	end

endmodule

// File: src/mcr3_input_pkg.sv
//==============================
// Shared input block definitions
// Game ids, download indexes, joystick bits,
// PS/2 scancodes, gear table, hold length
// and reset sequencer states
//==============================
package mcr3_input_pkg;

	typedef enum logic [7:0] {
		GAME_RAMPAGE    = 8'd0,
		GAME_SARGE      = 8'd1,
		GAME_POWERDRIVE = 8'd2,
		GAME_MAXRPM     = 8'd3,
		GAME_DEMDERBY   = 8'd4,
		GAME_STARGRDS   = 8'd5
	} game_id_t;

	// Download stream indexes
	localparam logic [7:0] DL_INDEX_ROM  = 8'd0;
	localparam logic [7:0] DL_INDEX_GAME = 8'd1;
	localparam logic [7:0] DL_INDEX_DIP  = 8'd254;
	localparam int DIP_BYTES = 2;

	// Joystick word bit positions
	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_FIRE_A = 4;
	localparam int JOY_FIRE_B = 5;
	localparam int JOY_FIRE_C = 6;
	localparam int JOY_FIRE_D = 7;
	localparam int JOY_START  = 8;
	localparam int JOY_COIN   = 9;

	//==============================
	// Set 2 scancodes
	//==============================
	localparam logic [7:0] KEY_UP     = 8'h75;
	localparam logic [7:0] KEY_DOWN   = 8'h72;
	localparam logic [7:0] KEY_LEFT   = 8'h6B;
	localparam logic [7:0] KEY_RIGHT  = 8'h74;
	localparam logic [7:0] KEY_ESC    = 8'h76;
	localparam logic [7:0] KEY_F1     = 8'h05;
	localparam logic [7:0] KEY_F2     = 8'h06;
	localparam logic [7:0] KEY_LCTRL  = 8'h14;
	localparam logic [7:0] KEY_LALT   = 8'h11;
	localparam logic [7:0] KEY_SPACE  = 8'h29;
	localparam logic [7:0] KEY_LSHIFT = 8'h12;
	// MAME style start and coin keys
	localparam logic [7:0] KEY_1      = 8'h16;
	localparam logic [7:0] KEY_2      = 8'h1E;
	localparam logic [7:0] KEY_5      = 8'h2E;
	localparam logic [7:0] KEY_6      = 8'h36;
	localparam logic [7:0] KEY_7      = 8'h3D;
	// Player 2 cluster
	localparam logic [7:0] KEY_R      = 8'h2D;
	localparam logic [7:0] KEY_F      = 8'h2B;
	localparam logic [7:0] KEY_D      = 8'h23;
	localparam logic [7:0] KEY_G      = 8'h34;
	localparam logic [7:0] KEY_A      = 8'h1C;
	localparam logic [7:0] KEY_S      = 8'h1B;
	localparam logic [7:0] KEY_Q      = 8'h15;
	localparam logic [7:0] KEY_W      = 8'h1D;

	// Max RPM gearbox, neutral is gear 0
	typedef logic [2:0] gear_t;
	localparam gear_t GEAR_TOP = 3'd4;
	localparam logic [3:0] MAXRPM_GEAR_CODE [0:GEAR_TOP] = '{4'h0, 4'h5, 4'h6, 4'h1, 4'h2};

	// Game reset low time after a ROM load
	localparam logic [15:0] HOLD_CYCLES = 16'd64;

	typedef enum logic [2:0] {WAIT_ROM, LOADING, HOLD, RUN, REQUEST} seq_state_t;

endpackage

// File: src/mcr3_input_top.sv
//==============================
// MCR3 mono player input block
// Top level wiring only
//==============================
`timescale 1ns/100ps

module mcr3_input_top import mcr3_input_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [10:0] ps2_key,
	input  logic [15:0] joy1,
	input  logic [15:0] joy2,
	input  logic [15:0] joy3,
	input  logic        ioctl_download,
	input  logic        ioctl_wr,
	input  logic [7:0]  ioctl_index,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0]  ioctl_dout,
	input  logic        reset_req,
	input  logic        snd_stat,
	output logic [7:0]  input0,
	output logic [7:0]  input1,
	output logic [7:0]  input2,
	output logic [7:0]  input3,
	output logic [7:0]  input4,
	output logic        game_reset,
	output logic        rom_loaded
);

	game_id_t   game;
	logic [7:0] dip0;
	logic [7:0] dip1;
	logic       hold_start;
	logic       hold_done;
	logic [3:0] maxrpm_code1;
	logic [3:0] maxrpm_code2;
	logic [2:0] pd_gear;

	player_ctl_if p1 ();
	player_ctl_if p2 ();
	player_ctl_if p3 ();

	player_controls u_player_controls (
		.clk_sys(clk_sys), .reset(reset), .ps2_key(ps2_key),
		.joy1(joy1), .joy2(joy2), .joy3(joy3), .game(game),
		.p1(p1.source), .p2(p2.source), .p3(p3.source)
	);

	game_config u_game_config (
		.clk_sys(clk_sys), .reset(reset), .ioctl_wr(ioctl_wr),
		.ioctl_index(ioctl_index), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.game(game), .dip0(dip0), .dip1(dip1)
	);

	reset_sequencer u_reset_sequencer (
		.clk_sys(clk_sys), .reset(reset), .ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index), .reset_req(reset_req), .hold_done(hold_done),
		.hold_start(hold_start), .game_reset(game_reset), .rom_loaded(rom_loaded)
	);

	hold_timer u_hold_timer (
		.clk_sys(clk_sys), .reset(reset), .hold_start(hold_start), .hold_done(hold_done)
	);

	gear_shift u_gear_shift (
		.clk_sys(clk_sys), .reset(reset),
		.p1(p1.sink), .p2(p2.sink), .p3(p3.sink),
		.maxrpm_code1(maxrpm_code1), .maxrpm_code2(maxrpm_code2), .pd_gear(pd_gear)
	);

	input_port_map u_input_port_map (
		.game(game), .dip0(dip0), .dip1(dip1), .snd_stat(snd_stat),
		.p1(p1.sink), .p2(p2.sink), .p3(p3.sink),
		.maxrpm_code1(maxrpm_code1), .maxrpm_code2(maxrpm_code2), .pd_gear(pd_gear),
		.input0(input0), .input1(input1), .input2(input2),
		.input3(input3), .input4(input4)
	);

endmodule

// File: src/player_controls.sv
//==============================
// Keyboard event decoder and joystick
// merge for three players
//==============================
`timescale 1ns/100ps

module player_controls import mcr3_input_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [10:0] ps2_key,
	input  logic [15:0] joy1,
	input  logic [15:0] joy2,
	input  logic [15:0] joy3,
	input  game_id_t    game,
	player_ctl_if.source p1,
	player_ctl_if.source p2,
	player_ctl_if.source p3
);

	logic       event_q;
	logic       key_pressed;
	logic [7:0] key_code;
	// Key buttons, laid out like the joystick word
	logic [9:0] btn1;
	logic [9:0] btn2;
	logic       btn_coin3;
	logic [9:0] m1;
	logic [9:0] m2;
	logic [9:0] m3;
	logic       pd_mode;

	assign key_pressed = ps2_key[9];
	assign key_code = ps2_key[7:0];

	// Bit 10 toggles once per key event
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			event_q <= 1'b0;
			btn1 <= '0;
			btn2 <= '0;
			btn_coin3 <= 1'b0;
		end else begin
			event_q <= ps2_key[10];
			if (event_q != ps2_key[10]) begin
				case (key_code)
					KEY_UP:        btn1[JOY_UP] <= key_pressed;
					KEY_DOWN:      btn1[JOY_DOWN] <= key_pressed;
					KEY_LEFT:      btn1[JOY_LEFT] <= key_pressed;
					KEY_RIGHT:     btn1[JOY_RIGHT] <= key_pressed;
					KEY_ESC, KEY_5: btn1[JOY_COIN] <= key_pressed;
					KEY_F1, KEY_1: btn1[JOY_START] <= key_pressed;
					KEY_F2, KEY_2: btn2[JOY_START] <= key_pressed;
					KEY_LCTRL:     btn1[JOY_FIRE_A] <= key_pressed;
					KEY_LALT:      btn1[JOY_FIRE_B] <= key_pressed;
					KEY_SPACE:     btn1[JOY_FIRE_C] <= key_pressed;
					KEY_LSHIFT:    btn1[JOY_FIRE_D] <= key_pressed;
					KEY_6:         btn2[JOY_COIN] <= key_pressed;
					KEY_7:         btn_coin3 <= key_pressed;
					KEY_R:         btn2[JOY_UP] <= key_pressed;
					KEY_F:         btn2[JOY_DOWN] <= key_pressed;
					KEY_D:         btn2[JOY_LEFT] <= key_pressed;
					KEY_G:         btn2[JOY_RIGHT] <= key_pressed;
					KEY_A:         btn2[JOY_FIRE_A] <= key_pressed;
					KEY_S:         btn2[JOY_FIRE_B] <= key_pressed;
					KEY_Q:         btn2[JOY_FIRE_C] <= key_pressed;
					KEY_W:         btn2[JOY_FIRE_D] <= key_pressed;
					default: ;
				endcase
			end
		end
	end

	assign m1 = btn1 | joy1[JOY_COIN:JOY_RIGHT];
	assign m2 = btn2 | joy2[JOY_COIN:JOY_RIGHT];
	// No keyboard cluster for player 3
	assign m3 = joy3[JOY_COIN:JOY_RIGHT];

	// Only Power Drive has separate coin slots per player
	assign pd_mode = (game == GAME_POWERDRIVE);
	assign p1.coin = pd_mode ? m1[JOY_COIN] :
		(m1[JOY_COIN] | m2[JOY_COIN] | m3[JOY_COIN] | btn_coin3);
	assign p2.coin = pd_mode & m2[JOY_COIN];
	assign p3.coin = pd_mode & m3[JOY_COIN];

	assign p1.up = m1[JOY_UP];
	assign p1.down = m1[JOY_DOWN];
	assign p1.left = m1[JOY_LEFT];
	assign p1.right = m1[JOY_RIGHT];
	assign p1.fire_a = m1[JOY_FIRE_A];
	assign p1.fire_b = m1[JOY_FIRE_B];
	assign p1.fire_c = m1[JOY_FIRE_C];
	assign p1.fire_d = m1[JOY_FIRE_D];
	assign p1.start = m1[JOY_START];

	assign p2.up = m2[JOY_UP];
	assign p2.down = m2[JOY_DOWN];
	assign p2.left = m2[JOY_LEFT];
	assign p2.right = m2[JOY_RIGHT];
	assign p2.fire_a = m2[JOY_FIRE_A];
	assign p2.fire_b = m2[JOY_FIRE_B];
	assign p2.fire_c = m2[JOY_FIRE_C];
	assign p2.fire_d = m2[JOY_FIRE_D];
	assign p2.start = m2[JOY_START];

	assign p3.up = m3[JOY_UP];
	assign p3.down = m3[JOY_DOWN];
	assign p3.left = m3[JOY_LEFT];
	assign p3.right = m3[JOY_RIGHT];
	assign p3.fire_a = m3[JOY_FIRE_A];
	assign p3.fire_b = m3[JOY_FIRE_B];
	assign p3.fire_c = m3[JOY_FIRE_C];
	assign p3.fire_d = m3[JOY_FIRE_D];
	assign p3.start = m3[JOY_START];

endmodule

// File: src/player_ctl_if.sv
//==============================
// Merged control levels of one player
//==============================
`timescale 1ns/100ps

interface player_ctl_if;

	// All levels are 1 while pressed
	logic up;
	logic down;
	logic left;
	logic right;
	logic fire_a;
	logic fire_b;
	logic fire_c;
	logic fire_d;
	logic start;
	logic coin;

	modport source (output up, down, left, right, fire_a, fire_b, fire_c, fire_d, start, coin);
	modport sink (input up, down, left, right, fire_a, fire_b, fire_c, fire_d, start, coin);

endinterface

// File: src/reset_sequencer.sv
//==============================
// Game reset sequencing around ROM
// download and user reset requests
//==============================
`timescale 1ns/100ps

module reset_sequencer import mcr3_input_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       ioctl_download,
	input  logic [7:0] ioctl_index,
	input  logic       reset_req,
	input  logic       hold_done,
	output logic       hold_start,
	output logic       game_reset,
	output logic       rom_loaded
);

	seq_state_t state;
	logic       rom_download;

	assign rom_download = ioctl_download && (ioctl_index == DL_INDEX_ROM);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= WAIT_ROM;
			hold_start <= 1'b0;
			game_reset <= 1'b1;
			rom_loaded <= 1'b0;
		end else begin
			hold_start <= 1'b0;
			if (rom_download) begin
				// A download restarts everything
				state <= LOADING;
				game_reset <= 1'b1;
			end else begin
				case (state)
					WAIT_ROM: game_reset <= 1'b1;
					LOADING: begin
						// Download just ended
						state <= HOLD;
						hold_start <= 1'b1;
						game_reset <= 1'b0;
						rom_loaded <= 1'b1;
					end
					HOLD: begin
						if (reset_req) begin
							state <= REQUEST;
							game_reset <= 1'b1;
						end else if (hold_done) begin
							// Second reset pulse, one cycle
							state <= RUN;
							game_reset <= 1'b1;
						end else begin
							game_reset <= 1'b0;
						end
					end
					RUN: begin
						if (reset_req)
							state <= REQUEST;
						game_reset <= reset_req;
					end
					REQUEST: begin
						if (!reset_req) begin
							state <= HOLD;
							hold_start <= 1'b1;
						end
						game_reset <= reset_req;
					end
					default: state <= WAIT_ROM;
				endcase
			end
		end
	end

endmodule

// File: tb/tb_mcr3_input.sv
//==============================
// Directed testbench for the MCR3 input block
// Reset sequencing, key and joystick mapping,
// Power Drive and Max RPM gears, idle ports
//==============================
`timescale 1ns/100ps

module tb_mcr3_input import mcr3_input_pkg::*; ();

	localparam int RANDOM_STEPS = 150;
	// Two hold sequences, the random phase, the directed phases and margin
	localparam int WATCHDOG_CYCLES = 2 * (int'(HOLD_CYCLES) + 40) + 2 * RANDOM_STEPS + 400;
	localparam logic [7:0] RANDOM_KEYS [0:13] = '{KEY_UP, KEY_DOWN, KEY_LEFT, KEY_RIGHT,
		KEY_LCTRL, KEY_LALT, KEY_5, KEY_R, KEY_F, KEY_D, KEY_G, KEY_A, KEY_S, KEY_6};

	logic        clk_sys;
	logic        reset;
	logic [10:0] ps2_key;
	logic [15:0] joy1;
	logic [15:0] joy2;
	logic [15:0] joy3;
	logic        ioctl_download;
	logic        ioctl_wr;
	logic [7:0]  ioctl_index;
	logic [24:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic        reset_req;
	logic        snd_stat;
	logic [7:0]  input0;
	logic [7:0]  input1;
	logic [7:0]  input2;
	logic [7:0]  input3;
	logic [7:0]  input4;
	logic        game_reset;
	logic        rom_loaded;

	// Reference model state
	logic [9:0]  kb1;
	logic [9:0]  kb2;
	logic [9:0]  kb1_next;
	logic [9:0]  kb2_next;
	logic        coin3_key;
	logic        coin3_next;
	logic [9:0]  lv1;
	logic [9:0]  lv2;
	logic [9:0]  lv3;
	logic [2:0]  gear1;
	logic [2:0]  gear2;
	logic [1:0]  prev_a;
	logic [1:0]  prev_b;
	logic [2:0]  prev_d;
	logic [2:0]  pd_m;
	logic [7:0]  game_m;
	logic [7:0]  dip0_m;
	logic [7:0]  dip1_m;
	logic [15:0] lfsr_state;
	int          value_errors;
	int          other_errors;

	mcr3_input_top u_dut (
		.clk_sys(clk_sys), .reset(reset), .ps2_key(ps2_key),
		.joy1(joy1), .joy2(joy2), .joy3(joy3),
		.ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr), .ioctl_index(ioctl_index),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.reset_req(reset_req), .snd_stat(snd_stat),
		.input0(input0), .input1(input1), .input2(input2), .input3(input3), .input4(input4),
		.game_reset(game_reset), .rom_loaded(rom_loaded)
	);

	// 20 ns clock
	always #10 clk_sys = ~clk_sys;

	assign lv1 = kb1 | joy1[9:0];
	assign lv2 = kb2 | joy2[9:0];
	assign lv3 = joy3[9:0];

	//==============================
	// Model helpers
	//==============================
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		// x^16 + x^14 + x^13 + x^11 + 1
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	function automatic logic [2:0] expected_gear(input logic [2:0] g, input logic start,
		input logic up, input logic down);
		int n;
		n = int'(g);
		if (up)
			n = n + 1;
		else if (down)
			n = n - 1;
		if (n > 4)
			n = 4;
		if (n < 0)
			n = 0;
		if (start)
			n = 0;
		return 3'(n);
	endfunction

	function automatic logic [3:0] gear_code(input logic [2:0] g);
		case (g)
			3'd1: return 4'h5;
			3'd2: return 4'h6;
			3'd3: return 4'h1;
			3'd4: return 4'h2;
			default: return 4'h0;
		endcase
	endfunction

	// fire_b, fire_a, left, down, right, up
	function automatic logic [5:0] stick_bits(input logic [9:0] lv);
		return {lv[JOY_FIRE_B], lv[JOY_FIRE_A], lv[JOY_LEFT], lv[JOY_DOWN],
			lv[JOY_RIGHT], lv[JOY_UP]};
	endfunction

	// Registered part of the model, timed like the block
	always @(posedge clk_sys) begin
		if (reset) begin
			kb1 <= '0;
			kb2 <= '0;
			coin3_key <= 1'b0;
			gear1 <= '0;
			gear2 <= '0;
			prev_a <= '0;
			prev_b <= '0;
			prev_d <= '0;
			pd_m <= '0;
			game_m <= 8'd0;
			dip0_m <= 8'hff;
			dip1_m <= 8'hff;
		end else begin
			kb1 <= kb1_next;
			kb2 <= kb2_next;
			coin3_key <= coin3_next;
			prev_a <= {lv2[JOY_FIRE_A], lv1[JOY_FIRE_A]};
			prev_b <= {lv2[JOY_FIRE_B], lv1[JOY_FIRE_B]};
			prev_d <= {lv3[JOY_FIRE_D], lv2[JOY_FIRE_D], lv1[JOY_FIRE_D]};
			gear1 <= expected_gear(gear1, lv1[JOY_START],
				lv1[JOY_FIRE_A] & ~prev_a[0], lv1[JOY_FIRE_B] & ~prev_b[0]);
			gear2 <= expected_gear(gear2, lv2[JOY_START],
				lv2[JOY_FIRE_A] & ~prev_a[1], lv2[JOY_FIRE_B] & ~prev_b[1]);
			pd_m <= pd_m ^ ({lv3[JOY_FIRE_D], lv2[JOY_FIRE_D], lv1[JOY_FIRE_D]} & ~prev_d);
			if (ioctl_wr && ioctl_index == DL_INDEX_GAME)
				game_m <= ioctl_dout;
			if (ioctl_wr && ioctl_index == DL_INDEX_DIP && ioctl_addr == 25'd0)
				dip0_m <= ioctl_dout;
			if (ioctl_wr && ioctl_index == DL_INDEX_DIP && ioctl_addr == 25'd1)
				dip1_m <= ioctl_dout;
		end
	end

	//==============================
	// Checks and stimulus tasks
	//==============================
	task automatic check_byte(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		assert (actual === expected) else begin
			value_errors++;
			$display("error at %0t ns: %s expected %02h, got %02h", $time, name, expected, actual);
		end
	endtask

	task automatic check_level(input string name, input logic expected, input logic actual);
		assert (actual === expected) else begin
			value_errors++;
			$display("error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		assert (actual == expected) else begin
			value_errors++;
			$display("error at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic take_bits(input int count, output logic [15:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[14:0], lfsr_state[0]};
		end
	endtask

	task automatic check_ports();
		logic [7:0] e0;
		logic [7:0] e1;
		logic [7:0] e2;
		logic [7:0] e4;
		logic       c1;
		logic       c2;
		logic       c3;
		e0 = 8'hff;
		e1 = 8'hff;
		e2 = 8'hff;
		e4 = 8'hff;
		if (game_m == 8'd2) begin
			c1 = lv1[JOY_COIN];
			c2 = lv2[JOY_COIN];
			c3 = lv3[JOY_COIN];
		end else begin
			c1 = lv1[JOY_COIN] | lv2[JOY_COIN] | lv3[JOY_COIN] | coin3_key;
			c2 = 1'b0;
			c3 = 1'b0;
		end
		case (game_m)
			8'd0: begin
				e0 = ~{2'b00, dip1_m[0], 3'b000, c2, c1};
				e1 = ~{2'b00, stick_bits(lv1)};
				e2 = ~{2'b00, stick_bits(lv2)};
				e4 = ~{snd_stat, 1'b0, stick_bits(lv3)};
			end
			8'd2: begin
				e0 = ~{2'b00, dip1_m[0], 2'b00, c3, c2, c1};
				e1 = ~{lv2[JOY_FIRE_B], lv2[JOY_FIRE_A], pd_m[1], lv2[JOY_FIRE_C],
					lv1[JOY_FIRE_B], lv1[JOY_FIRE_A], pd_m[0], lv1[JOY_FIRE_C]};
				e2 = ~{snd_stat, 3'b000, lv3[JOY_FIRE_B], lv3[JOY_FIRE_A], pd_m[2],
					lv3[JOY_FIRE_C]};
			end
			8'd3: begin
				e0 = ~{dip1_m[0], 3'b000, lv1[JOY_START], lv2[JOY_START], c1, c2};
				e2 = {gear_code(gear1), gear_code(gear2)};
			end
			default: ;
		endcase
		check_byte("input0", e0, input0);
		check_byte("input1", e1, input1);
		check_byte("input2", e2, input2);
		check_byte("input3", dip0_m, input3);
		check_byte("input4", e4, input4);
	endtask

	task automatic tick_check();
		@(negedge clk_sys);
		check_ports();
	endtask

	task automatic ticks(input int count);
		repeat (count) tick_check();
	endtask

	task automatic apply_reset();
		@(negedge clk_sys);
		reset = 1'b1;
		ps2_key = '0;
		joy1 = '0;
		joy2 = '0;
		joy3 = '0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		reset_req = 1'b0;
		snd_stat = 1'b0;
		kb1_next = '0;
		kb2_next = '0;
		coin3_next = 1'b0;
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	// Key table of the two keyboard clusters
	task automatic update_key_model(input logic [7:0] code, input logic pressed);
		case (code)
			KEY_UP: kb1_next[JOY_UP] = pressed;
			KEY_DOWN: kb1_next[JOY_DOWN] = pressed;
			KEY_LEFT: kb1_next[JOY_LEFT] = pressed;
			KEY_RIGHT: kb1_next[JOY_RIGHT] = pressed;
			KEY_LCTRL: kb1_next[JOY_FIRE_A] = pressed;
			KEY_LALT: kb1_next[JOY_FIRE_B] = pressed;
			KEY_SPACE: kb1_next[JOY_FIRE_C] = pressed;
			KEY_LSHIFT: kb1_next[JOY_FIRE_D] = pressed;
			KEY_ESC, KEY_5: kb1_next[JOY_COIN] = pressed;
			KEY_F1, KEY_1: kb1_next[JOY_START] = pressed;
			KEY_F2, KEY_2: kb2_next[JOY_START] = pressed;
			KEY_6: kb2_next[JOY_COIN] = pressed;
			KEY_7: coin3_next = pressed;
			KEY_R: kb2_next[JOY_UP] = pressed;
			KEY_F: kb2_next[JOY_DOWN] = pressed;
			KEY_D: kb2_next[JOY_LEFT] = pressed;
			KEY_G: kb2_next[JOY_RIGHT] = pressed;
			KEY_A: kb2_next[JOY_FIRE_A] = pressed;
			KEY_S: kb2_next[JOY_FIRE_B] = pressed;
			KEY_Q: kb2_next[JOY_FIRE_C] = pressed;
			KEY_W: kb2_next[JOY_FIRE_D] = pressed;
			default: ;
		endcase
	endtask

	// Bit 10 flips to mark a new event
	task automatic drive_key(input logic [7:0] code, input logic pressed);
		ps2_key = {~ps2_key[10], pressed, 1'b0, code};
		update_key_model(code, pressed);
	endtask

	task automatic pulse_key(input logic [7:0] code);
		drive_key(code, 1'b1);
		ticks(2);
		drive_key(code, 1'b0);
		ticks(2);
	endtask

	task automatic set_joy_bit(input int player, input int bit_index, input logic value);
		case (player)
			1: joy1[bit_index] = value;
			2: joy2[bit_index] = value;
			default: joy3[bit_index] = value;
		endcase
	endtask

	task automatic pulse_joy(input int player, input int bit_index);
		set_joy_bit(player, bit_index, 1'b1);
		ticks(2);
		set_joy_bit(player, bit_index, 1'b0);
		ticks(2);
	endtask

	task automatic ioctl_write(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		ioctl_index = index;
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr = 1'b1;
		tick_check();
		ioctl_wr = 1'b0;
		tick_check();
	endtask

	task automatic randomize_joys();
		logic [15:0] r;
		take_bits(10, r);
		joy1 = {6'd0, r[9:0]};
		take_bits(10, r);
		joy2 = {6'd0, r[9:0]};
		take_bits(10, r);
		joy3 = {6'd0, r[9:0]};
		take_bits(1, r);
		snd_stat = r[0];
	endtask

	// Low time, then the single second pulse
	task automatic measure_hold();
		int waited;
		int low_count;
		int high_count;
		waited = 0;
		while (game_reset && waited < 20) begin
			@(negedge clk_sys);
			waited++;
		end
		assert (!game_reset) else begin
			other_errors++;
			$display("game_reset did not drop within 20 cycles after the release");
		end
		low_count = 0;
		while (!game_reset && low_count < int'(HOLD_CYCLES) + 10) begin
			low_count++;
			@(negedge clk_sys);
		end
		check_count("game_reset low cycles", int'(HOLD_CYCLES), low_count);
		high_count = 0;
		while (game_reset && high_count < 10) begin
			high_count++;
			@(negedge clk_sys);
		end
		check_count("game_reset pulse cycles", 1, high_count);
		repeat (3) begin
			check_level("game_reset", 1'b0, game_reset);
			@(negedge clk_sys);
		end
	endtask

	//==============================
	// Tests
	//==============================
	task automatic check_startup_and_load();
		repeat (10) begin
			@(negedge clk_sys);
			check_level("game_reset", 1'b1, game_reset);
			check_level("rom_loaded", 1'b0, rom_loaded);
		end
		ioctl_index = DL_INDEX_ROM;
		ioctl_download = 1'b1;
		repeat (5) @(negedge clk_sys);
		check_level("game_reset", 1'b1, game_reset);
		check_level("rom_loaded", 1'b0, rom_loaded);
		ioctl_download = 1'b0;
		measure_hold();
		check_level("rom_loaded", 1'b1, rom_loaded);
	endtask

	task automatic check_reset_request();
		reset_req = 1'b1;
		repeat (6) begin
			@(negedge clk_sys);
			check_level("game_reset", 1'b1, game_reset);
		end
		reset_req = 1'b0;
		measure_hold();
		check_level("rom_loaded", 1'b1, rom_loaded);
	endtask

	task automatic check_rampage();
		logic [15:0] r;
		int idx;
		apply_reset();
		ioctl_write(DL_INDEX_DIP, 25'd0, 8'hA5);
		ioctl_write(DL_INDEX_DIP, 25'd1, 8'hFE);
		check_byte("input3", 8'hA5, input3);
		check_byte("input0", 8'hFF, input0);
		drive_key(KEY_UP, 1'b1);
		tick_check();
		check_byte("input1", 8'hFE, input1);
		drive_key(KEY_A, 1'b1);
		tick_check();
		check_byte("input2", 8'hEF, input2);
		drive_key(KEY_UP, 1'b0);
		tick_check();
		drive_key(KEY_A, 1'b0);
		tick_check();
		repeat (RANDOM_STEPS) begin
			randomize_joys();
			take_bits(2, r);
			if (r[1:0] == 2'b00) begin
				take_bits(4, r);
				idx = int'(r[3:0]) % 14;
				take_bits(1, r);
				drive_key(RANDOM_KEYS[idx], r[0]);
			end
			tick_check();
		end
	endtask

	task automatic check_power_drive();
		apply_reset();
		ioctl_write(DL_INDEX_GAME, 25'd0, 8'd2);
		pulse_key(KEY_LSHIFT);
		pulse_joy(2, JOY_FIRE_D);
		pulse_joy(3, JOY_FIRE_D);
		check_byte("input1", 8'hDD, input1);
		check_byte("input2", 8'hFD, input2);
		pulse_key(KEY_LSHIFT);
		check_byte("input1", 8'hDF, input1);
		pulse_joy(1, JOY_COIN);
		pulse_key(KEY_6);
		joy3[JOY_COIN] = 1'b1;
		tick_check();
		check_byte("input0", 8'hDB, input0);
		joy3[JOY_COIN] = 1'b0;
		ticks(2);
	endtask

	task automatic check_max_rpm();
		apply_reset();
		ioctl_write(DL_INDEX_GAME, 25'd0, 8'd3);
		repeat (6) pulse_key(KEY_LCTRL);
		check_byte("input2", 8'h20, input2);
		repeat (2) pulse_key(KEY_LALT);
		check_byte("input2", 8'h60, input2);
		pulse_key(KEY_1);
		check_byte("input2", 8'h00, input2);
		repeat (2) pulse_joy(2, JOY_FIRE_A);
		check_byte("input2", 8'h06, input2);
		pulse_key(KEY_S);
		check_byte("input2", 8'h05, input2);
		pulse_joy(2, JOY_START);
		pulse_key(KEY_S);
		check_byte("input2", 8'h00, input2);
	endtask

	task automatic check_unsupported_game();
		apply_reset();
		ioctl_write(DL_INDEX_GAME, 25'd0, 8'd5);
		repeat (20) begin
			randomize_joys();
			tick_check();
		end
		check_byte("input1", 8'hFF, input1);
	endtask

	//==============================
	// Main sequence and watchdog
	//==============================
	initial begin
		clk_sys = 1'b0;
		reset = 1'b1;
		ps2_key = '0;
		joy1 = '0;
		joy2 = '0;
		joy3 = '0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		reset_req = 1'b0;
		snd_stat = 1'b0;
		kb1_next = '0;
		kb2_next = '0;
		coin3_next = 1'b0;
		lfsr_state = 16'd98;
		value_errors = 0;
		other_errors = 0;
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;
		check_startup_and_load();
		check_reset_request();
		check_rampage();
		check_power_drive();
		check_max_rpm();
		check_unsupported_game();
		$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * 20);
		$display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

endmodule
